// ==== rtl/mem_cfg_pkg.sv ====
// ------------------------------------------------------------
// Data memory configuration: word and address sizes, I/O map,
// and the address word seen both as raw and as page plus port
// ------------------------------------------------------------
`default_nettype none

package mem_cfg_pkg;

    // Core sizes
    localparam int WORD_WIDTH         = 32;
    localparam int ADDR_WIDTH         = 10;
    localparam int MEM_DEPTH          = 1024;

    // I/O ports live in the top page of the address space
    localparam int IO_PORT_COUNT      = 4;
    localparam int IO_PORT_ADDR_WIDTH = 2;
    localparam int IO_PAGE_WIDTH      = ADDR_WIDTH - IO_PORT_ADDR_WIDTH;
    localparam logic [IO_PAGE_WIDTH-1:0] IO_PAGE = '1;

    typedef logic [WORD_WIDTH-1:0]         word_t;
    typedef logic [ADDR_WIDTH-1:0]         addr_t;
    typedef logic [IO_PORT_ADDR_WIDTH-1:0] io_idx_t;
    typedef logic [IO_PORT_COUNT-1:0]      io_onehot_t;

    // Page in the high bits, port index in the low bits
    typedef struct packed {
        logic [IO_PAGE_WIDTH-1:0] page;
        io_idx_t                  port;
    } io_addr_t;

    // Same address word, decoded either way
    typedef union packed {
        addr_t    raw;
        io_addr_t io;
    } addr_view_u;

endpackage

`default_nettype wire

// ==== rtl/mem_types_pkg.sv ====
// ------------------------------------------------------------
// Data memory transfer types: external requests, decoded
// commands and the per-port I/O word array
// ------------------------------------------------------------
`default_nettype none

package mem_types_pkg;

    import mem_cfg_pkg::*;

    // Read request as presented by the processor
    typedef struct packed {
        logic  en;
        addr_t addr;
    } mem_rd_req_t;

    // Write request as presented by the processor
    typedef struct packed {
        logic  en;
        addr_t addr;
        word_t data;
    } mem_wr_req_t;

    // Read command after decode, tagged RAM or I/O
    typedef struct packed {
        logic  en;
        logic  is_io;
        addr_t addr;
    } mem_rd_cmd_t;

    // Write command after decode, tagged RAM or I/O
    typedef struct packed {
        logic  en;
        logic  is_io;
        addr_t addr;
        word_t data;
    } mem_wr_cmd_t;

    // One word per I/O port, index 0 in the low bits
    typedef word_t [IO_PORT_COUNT-1:0] io_words_t;

endpackage

`default_nettype wire

// ==== rtl/sdp_ram.sv ====
// ------------------------------------------------------------
// Simple dual-port RAM, one write port and one registered read
// port, with write-to-read forwarding on a shared address
// ------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module sdp_ram
    import mem_cfg_pkg::*;
(
    input  wire logic  clock,
    input  wire logic  wren,
    input  wire addr_t write_addr,
    input  wire word_t write_data,
    input  wire logic  rden,
    input  wire addr_t read_addr,
    output word_t      read_data
);

    // Storage array, contents undefined at power up
    word_t mem [MEM_DEPTH];

    logic fwd_hit;

    // ------------------------------------------------------------
    // Write port

    always_ff @(posedge clock) begin
        if (wren) begin
            mem[write_addr] <= write_data;
        end
    end

    // ------------------------------------------------------------
    // Read port

    // Same edge write to the address being read
    assign fwd_hit = wren && (write_addr == read_addr);

    // Output holds its last value while rden is low
    always_ff @(posedge clock) begin
        if (rden) begin
            if (fwd_hit) begin
                read_data <= write_data;
            end else begin
                read_data <= mem[read_addr];
            end
        end
    end

    // ------------------------------------------------------------
    // Checks

    // Enabled reads use a known address inside the array
    a_read_in_range : assert property (
        @(posedge clock) rden |->
            (!$isunknown(read_addr) && (int'(read_addr) < MEM_DEPTH))
    );

endmodule

`default_nettype wire

// ==== rtl/io_port_regs.sv ====
// ------------------------------------------------------------
// I/O write ports: one-hot port strobe and one held output
// word per port
// ------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module io_port_regs
    import mem_cfg_pkg::*;
    import mem_types_pkg::*;
(
    input  wire logic    clock,
    input  wire logic    arst_n,
    input  wire logic    wr_en,
    input  wire io_idx_t wr_port,
    input  wire word_t   wr_data,
    output io_onehot_t   io_wren,
    output io_words_t    io_write_data
);

    io_onehot_t strobe;

    // ------------------------------------------------------------
    // Port decode

    // Only the addressed port sees the strobe
    always_comb begin
        strobe = '0;
        if (wr_en) begin
            strobe[wr_port] = 1'b1;
        end
    end

    // ------------------------------------------------------------
    // Strobe and port registers

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            io_wren       <= '0;
            io_write_data <= '0;
        end else begin
            io_wren <= strobe;
            // Untouched ports keep their last word
            for (int i = 0; i < IO_PORT_COUNT; i++) begin
                if (strobe[i]) begin
                    io_write_data[i] <= wr_data;
                end
            end
        end
    end

    // ------------------------------------------------------------
    // Checks

    // At most one port is written per cycle
    a_wren_onehot0 : assert property (
        @(posedge clock) disable iff (!arst_n) $onehot0(io_wren)
    );

endmodule

`default_nettype wire

// ==== rtl/access_decode.sv ====
// ------------------------------------------------------------
// Request decode: registers read and write requests and tags
// each one as a RAM or an I/O port access
// ------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module access_decode
    import mem_cfg_pkg::*;
    import mem_types_pkg::*;
(
    input  wire logic        clock,
    input  wire logic        arst_n,
    input  wire mem_rd_req_t rd_req,
    input  wire mem_wr_req_t wr_req,
    output mem_rd_cmd_t      rd_cmd,
    output mem_wr_cmd_t      wr_cmd
);

    addr_view_u rd_view;
    addr_view_u wr_view;
    logic       rd_is_io;
    logic       wr_is_io;

    // ------------------------------------------------------------
    // I/O page test

    assign rd_view.raw = rd_req.addr;
    assign wr_view.raw = wr_req.addr;

    // Top page shadows the RAM with the I/O ports
    assign rd_is_io = (rd_view.io.page == IO_PAGE);
    assign wr_is_io = (wr_view.io.page == IO_PAGE);

    // ------------------------------------------------------------
    // Command registers

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            rd_cmd <= '0;
            wr_cmd <= '0;
        end else begin
            rd_cmd.en    <= rd_req.en;
            rd_cmd.is_io <= rd_is_io;
            rd_cmd.addr  <= rd_req.addr;

            wr_cmd.en    <= wr_req.en;
            wr_cmd.is_io <= wr_is_io;
            wr_cmd.addr  <= wr_req.addr;
            wr_cmd.data  <= wr_req.data;
        end
    end

endmodule

`default_nettype wire

// ==== rtl/memory_io.sv ====
// ------------------------------------------------------------
// Memory block: two-stage reads from RAM or an I/O input word,
// two-stage writes to RAM or an I/O output port
// ------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module memory_io
    import mem_cfg_pkg::*;
    import mem_types_pkg::*;
(
    input  wire logic        clock,
    input  wire logic        arst_n,
    input  wire mem_rd_cmd_t rd_cmd,
    input  wire mem_wr_cmd_t wr_cmd,
    input  wire io_words_t   io_read_data,
    output word_t            read_data,
    output io_onehot_t       io_wren,
    output io_words_t        io_write_data
);

    // ------------------------------------------------------------
    // Read stage 1

    addr_view_u rd_view;
    logic       ram_rden;
    word_t      ram_rdata;
    word_t      io_sel_q;
    logic       rd_en_q;
    logic       rd_io_q;

    assign rd_view.raw = rd_cmd.addr;

    // RAM stays idle for disabled reads and for I/O reads
    assign ram_rden = rd_cmd.en && !rd_cmd.is_io;

    // Pick the input port by the low address bits
    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            io_sel_q <= '0;
            rd_en_q  <= 1'b0;
            rd_io_q  <= 1'b0;
        end else begin
            io_sel_q <= io_read_data[rd_view.io.port];
            rd_en_q  <= rd_cmd.en;
            rd_io_q  <= rd_cmd.is_io;
        end
    end

    // ------------------------------------------------------------
    // Read stage 2

    word_t rd_mux;

    // I/O word or RAM word, zero if the read was not enabled
    always_comb begin
        rd_mux = rd_io_q ? io_sel_q : ram_rdata;
        if (!rd_en_q) begin
            rd_mux = '0;
        end
    end

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            read_data <= '0;
        end else begin
            read_data <= rd_mux;
        end
    end

    // ------------------------------------------------------------
    // Write stage 1

    mem_wr_cmd_t wr_q;

    always_ff @(posedge clock or negedge arst_n) begin
        if (!arst_n) begin
            wr_q <= '0;
        end else begin
            wr_q <= wr_cmd;
        end
    end

    // ------------------------------------------------------------
    // Write stage 2

    addr_view_u wr_view;
    logic       ram_wren;
    logic       io_wr_en;

    assign wr_view.raw = wr_q.addr;

    // I/O writes never reach the RAM
    assign ram_wren = wr_q.en && !wr_q.is_io;
    assign io_wr_en = wr_q.en && wr_q.is_io;

    sdp_ram ram_i (
        .clock      (clock),
        .wren       (ram_wren),
        .write_addr (wr_q.addr),
        .write_data (wr_q.data),
        .rden       (ram_rden),
        .read_addr  (rd_cmd.addr),
        .read_data  (ram_rdata)
    );

    io_port_regs io_regs_i (
        .clock         (clock),
        .arst_n        (arst_n),
        .wr_en         (io_wr_en),
        .wr_port       (wr_view.io.port),
        .wr_data       (wr_q.data),
        .io_wren       (io_wren),
        .io_write_data (io_write_data)
    );

    // ------------------------------------------------------------
    // Checks

    // A port strobe comes from a stage 2 write that left the RAM alone
    a_io_not_ram : assert property (
        @(posedge clock) disable iff (!arst_n)
        (|io_wren) |-> !$past(ram_wren)
    );

endmodule

`default_nettype wire

// ==== rtl/data_memory_top.sv ====
// ------------------------------------------------------------
// Data memory with memory-mapped I/O, decode stage followed
// by the RAM and port block
// ------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module data_memory_top
    import mem_cfg_pkg::*;
    import mem_types_pkg::*;
(
    input  wire logic        clock,
    input  wire logic        arst_n,
    input  wire mem_rd_req_t rd_req,
    input  wire mem_wr_req_t wr_req,
    input  wire io_words_t   io_read_data,
    output word_t            read_data,
    output io_onehot_t       io_wren,
    output io_words_t        io_write_data
);

    // Decoded commands between the two stages
    mem_rd_cmd_t rd_cmd;
    mem_wr_cmd_t wr_cmd;

    access_decode decode_i (
        .clock  (clock),
        .arst_n (arst_n),
        .rd_req (rd_req),
        .wr_req (wr_req),
        .rd_cmd (rd_cmd),
        .wr_cmd (wr_cmd)
    );

    memory_io mem_i (
        .clock         (clock),
        .arst_n        (arst_n),
        .rd_cmd        (rd_cmd),
        .wr_cmd        (wr_cmd),
        .io_read_data  (io_read_data),
        .read_data     (read_data),
        .io_wren       (io_wren),
        .io_write_data (io_write_data)
    );

endmodule

`default_nettype wire

// ==== tb/tb_data_memory.sv ====
// ------------------------------------------------------------
// Data memory testbench: random RAM and I/O traffic checked
// against a reference model of RAM, ports and latencies
// ------------------------------------------------------------
`timescale 1ns/1ps
`default_nettype none

module tb_data_memory
    import mem_cfg_pkg::*;
    import mem_types_pkg::*;
();

    localparam int CLK_PERIOD  = 40;
    // Edges from driving a request to seeing its result
    localparam int CHECK_DELAY = 4;
    localparam int RAM_TOP     = MEM_DEPTH - IO_PORT_COUNT;
    localparam int DRAIN_LIMIT = 20;

    // Expected read result, resolved at check time for I/O reads
    typedef struct packed {
        int      cyc;
        logic    en;
        logic    is_io;
        io_idx_t port;
        word_t   ram_word;
    } rd_exp_t;

    // Expected port strobe and port words
    typedef struct packed {
        int         cyc;
        io_onehot_t wren;
        io_words_t  words;
    } wr_exp_t;

    logic        clock;
    logic        arst_n;
    mem_rd_req_t rd_req;
    mem_wr_req_t wr_req;
    io_words_t   io_read_data;
    word_t       read_data;
    io_onehot_t  io_wren;
    io_words_t   io_write_data;

    // Reference model
    word_t     model_ram [MEM_DEPTH];
    io_words_t model_ports;
    io_words_t io_hist [3];
    rd_exp_t   rd_exp_q [$];
    wr_exp_t   wr_exp_q [$];

    integer seed;
    int     cyc;
    int     mismatch_count;
    int     timeout_count;
    string  test_name;

    data_memory_top dut_i (
        .clock         (clock),
        .arst_n        (arst_n),
        .rd_req        (rd_req),
        .wr_req        (wr_req),
        .io_read_data  (io_read_data),
        .read_data     (read_data),
        .io_wren       (io_wren),
        .io_write_data (io_write_data)
    );

    always #(CLK_PERIOD / 2) clock = ~clock;

    // ------------------------------------------------------------
    // Compare tasks

    task automatic check_word(input string name, input word_t expected, input word_t actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("mismatch %s expected %h actual %h", name, expected, actual);
        end
    endtask

    task automatic check_wren(input string name, input io_onehot_t expected,
                              input io_onehot_t actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("mismatch %s expected %b actual %b", name, expected, actual);
        end
    endtask

    task automatic check_io_words(input string name, input io_words_t expected,
                                  input io_words_t actual);
        if (actual !== expected) begin
            mismatch_count++;
            $display("mismatch %s expected %h actual %h", name, expected, actual);
        end
    endtask

    // ------------------------------------------------------------
    // Stimulus helpers

    // Mostly anywhere in RAM, sometimes a small window to force collisions
    function automatic addr_t pick_ram_addr();
        if (($random(seed) & 3) == 0) begin
            return addr_t'($unsigned($random(seed)) % 8);
        end
        return addr_t'($unsigned($random(seed)) % RAM_TOP);
    endfunction

    // Half the time one of the I/O ports
    function automatic addr_t pick_any_addr();
        if (($random(seed) & 1) != 0) begin
            return addr_t'(RAM_TOP + ($unsigned($random(seed)) % IO_PORT_COUNT));
        end
        return pick_ram_addr();
    endfunction

    // Preload pattern over the whole address
    function automatic word_t fill_word(input addr_t addr);
        return {addr ^ 10'h2b5, 12'hc3a, addr};
    endfunction

    // Check every result due on this edge
    task automatic check_due();
        rd_exp_t re;
        wr_exp_t we;
        word_t   exp_word;
        while (rd_exp_q.size() > 0 && rd_exp_q[0].cyc + CHECK_DELAY == cyc) begin
            re = rd_exp_q.pop_front();
            // I/O word as driven on the edge after the request was sampled
            if (!re.en) begin
                exp_word = '0;
            end else if (re.is_io) begin
                exp_word = io_hist[2][re.port];
            end else begin
                exp_word = re.ram_word;
            end
            check_word({test_name, " read_data"}, exp_word, read_data);
        end
        while (wr_exp_q.size() > 0 && wr_exp_q[0].cyc + CHECK_DELAY == cyc) begin
            we = wr_exp_q.pop_front();
            check_wren({test_name, " io_wren"}, we.wren, io_wren);
            check_io_words({test_name, " io_write_data"}, we.words, io_write_data);
        end
    endtask

    // One clock edge: check, drive, then update the model
    task automatic step(input mem_rd_req_t rd, input mem_wr_req_t wr, input bit track);
        rd_exp_t   re;
        wr_exp_t   we;
        io_words_t io_new;
        io_idx_t   wr_port;
        @(posedge clock);
        cyc++;
        check_due();

        for (int i = 0; i < IO_PORT_COUNT; i++) begin
            io_new[i] = $random(seed);
        end
        io_hist[2] = io_hist[1];
        io_hist[1] = io_hist[0];
        io_hist[0] = io_new;

        rd_req       <= rd;
        wr_req       <= wr;
        io_read_data <= io_new;

        // Read sees writes driven earlier, not the one on this edge
        re.cyc      = cyc;
        re.en       = rd.en;
        re.is_io    = int'(rd.addr) >= RAM_TOP;
        re.port     = io_idx_t'(int'(rd.addr) - RAM_TOP);
        re.ram_word = model_ram[rd.addr];

        we.cyc  = cyc;
        we.wren = '0;
        wr_port = io_idx_t'(int'(wr.addr) - RAM_TOP);
        if (wr.en) begin
            // Port writes leave the shadowed RAM alone
            if (int'(wr.addr) >= RAM_TOP) begin
                model_ports[wr_port] = wr.data;
                we.wren = io_onehot_t'(1 << wr_port);
            end else begin
                model_ram[wr.addr] = wr.data;
            end
        end
        we.words = model_ports;

        if (track) begin
            rd_exp_q.push_back(re);
            wr_exp_q.push_back(we);
        end
    endtask

    // Random traffic, RAM only or with the I/O page mixed in
    task automatic run_traffic(input int cycles, input bit with_io);
        mem_rd_req_t rd;
        mem_wr_req_t wr;
        for (int n = 0; n < cycles; n++) begin
            rd.en   = ($random(seed) & 1) != 0;
            rd.addr = with_io ? pick_any_addr() : pick_ram_addr();
            wr.en   = ($random(seed) & 1) != 0;
            wr.addr = with_io ? pick_any_addr() : pick_ram_addr();
            wr.data = $random(seed);
            step(rd, wr, 1'b1);
        end
    endtask

    // ------------------------------------------------------------
    // Main sequence

    initial begin
        mem_rd_req_t rd;
        mem_wr_req_t wr;
        int          wait_cycles;
        seed           = 32'hb626d519;
        clock          = 1'b0;
        arst_n         = 1'b0;
        rd_req         = '0;
        wr_req         = '0;
        io_read_data   = '0;
        model_ports    = '0;
        cyc            = 0;
        mismatch_count = 0;
        timeout_count  = 0;
        for (int i = 0; i < 3; i++) begin
            io_hist[i] = '0;
        end

        test_name = "reset";
        repeat (3) @(posedge clock);
        arst_n <= 1'b1;
        @(negedge clock);
        check_word("reset read_data", '0, read_data);
        check_wren("reset io_wren", '0, io_wren);
        check_io_words("reset io_write_data", '0, io_write_data);

        // Fill every RAM word, reads off at random addresses
        test_name = "ram_preload";
        for (int a = 0; a < RAM_TOP; a++) begin
            rd.en   = 1'b0;
            rd.addr = pick_any_addr();
            wr.en   = 1'b1;
            wr.addr = addr_t'(a);
            wr.data = fill_word(addr_t'(a));
            step(rd, wr, 1'b1);
        end

        test_name = "ram_traffic";
        run_traffic(2000, 1'b0);
        test_name = "mixed_io";
        run_traffic(1000, 1'b1);

        // Idle until every expected result has been seen
        wait_cycles = 0;
        while ((rd_exp_q.size() > 0 || wr_exp_q.size() > 0) && wait_cycles < DRAIN_LIMIT) begin
            step('0, '0, 1'b0);
            wait_cycles++;
        end
        if (rd_exp_q.size() > 0 || wr_exp_q.size() > 0) begin
            timeout_count++;
            $display("timeout: results still pending after %0d idle cycles", DRAIN_LIMIT);
        end

        $display("errors: %0d mismatches, %0d timeouts", mismatch_count, timeout_count);
        if (mismatch_count == 0 && timeout_count == 0) begin
            $display("TEST PASS");
        end else begin
            $display("TEST FAIL");
        end
        $finish;
    end

endmodule

`default_nettype wire

// ==== filelist.f ====
rtl/mem_cfg_pkg.sv
rtl/mem_types_pkg.sv
rtl/sdp_ram.sv
rtl/io_port_regs.sv
rtl/access_decode.sv
rtl/memory_io.sv
rtl/data_memory_top.sv
tb/tb_data_memory.sv

// ==== run_sim.sh ====
#!/bin/sh
# Build and run the data memory testbench with Verilator
cd "$(dirname "$0")" || exit 1

LOG=sim.log
rm -f "$LOG" build.log

verilator --binary --assert --timescale 1ns/1ps --top-module tb_data_memory \
    -f filelist.f -o sim_tb > build.log 2>&1 \
    && ./obj_dir/sim_tb > "$LOG" 2>&1 \
    || { echo "build or simulation did not complete"; cat build.log "$LOG" 2>/dev/null; exit 1; }

grep -qx "TEST PASS" "$LOG" \
    && { echo "simulation passed"; exit 0; } \
    || { echo "simulation failed"; cat "$LOG"; exit 1; }
